//--- hw/barrel_settings.svh
// Core dimensions: slice count, registers per slice, bus widths and slice start addresses
`ifndef BARREL_SETTINGS_SVH
`define BARREL_SETTINGS_SVH

// Number of hardware threads that share the pipeline in rotation
`define BARREL_SLICES 4
`define BARREL_SLICE_W $clog2(`BARREL_SLICES)

// General purpose registers per slice
`define BARREL_REGS 8
`define BARREL_REG_W $clog2(`BARREL_REGS)

// Instruction memory is addressed in 16-bit instruction words
`define BARREL_IADDR_W 10
`define BARREL_INSTR_W 16

// Data path and data bus width, with one mask bit per byte lane
`define BARREL_DATA_W 32
`define BARREL_LANES (`BARREL_DATA_W / 8)

// Slice s begins executing at s * BARREL_SLICE_BASE instruction words
`define BARREL_SLICE_BASE 64

`endif

//--- hw/barrel_pkg.sv
// Opcode enumeration, arithmetic and memory instruction views, and the instruction union
package barrel_pkg;

  // Operation codes of the arithmetic class
  typedef enum logic [3:0] {
    OP_ADD  = 4'd0,
    OP_SUB  = 4'd1,
    OP_AND  = 4'd2,
    OP_OR   = 4'd3,
    OP_XOR  = 4'd4,
    OP_SHL  = 4'd5,
    OP_SHR  = 4'd6,
    OP_MOVI = 4'd7,
    OP_BZ   = 4'd8,
    OP_BRA  = 4'd9
  } opcode_e;

  // Arithmetic view, class bit clear
  // The 5-bit immediate is bits 4..0, so it includes the immediate flag itself
  // For movi and the branches bits 7..0 are one 8-bit field
  typedef struct packed {
    logic       cls;
    opcode_e    op;
    logic [2:0] rd;
    logic [2:0] ra;
    logic       is_imm;
    logic       imm_b3;
    logic [2:0] rb;
  } au_instr_t;

  // Memory view, class bit set
  // Rd is the load destination or the store source
  typedef struct packed {
    logic       cls;
    logic       load;
    logic       byte_op;
    logic [1:0] spare;
    logic [2:0] rd;
    logic [2:0] ptr;
    logic [4:0] offset;
  } ls_instr_t;

  // One instruction word, decoded as either view depending on bit 15
  typedef union packed {
    au_instr_t au;
    ls_instr_t ls;
  } instr_u;

endpackage

//--- hw/barrel_fetch.sv
// Slice rotation, per-slice program counters, instruction decode and branch resolution
`timescale 1ns/10ps
`include "barrel_settings.svh"

module barrel_fetch import barrel_pkg::*; (
  input  logic                         clk,
  input  logic                         arst_n,
  input  logic [`BARREL_INSTR_W-1:0]   idata,
  input  logic [`BARREL_SLICES-1:0]    au_flags,
  output logic [`BARREL_IADDR_W-1:0]   iaddr,
  output logic [`BARREL_SLICE_W-1:0]   slice,
  output logic                         au_op_vld,
  output au_instr_t                    au_instr,
  output logic                         ls_op_vld,
  output ls_instr_t                    ls_instr
);

  logic [`BARREL_IADDR_W-1:0] pc [`BARREL_SLICES];
  logic [`BARREL_SLICE_W-1:0] fetch_slice;
  logic [`BARREL_SLICE_W-1:0] next_slice;
  logic                       dec_vld;
  instr_u                     word;
  logic [7:0]                 br_field;
  logic [`BARREL_IADDR_W-1:0] br_off;
  logic                       taken;

  // The word on idata belongs to the slice that was fetched last cycle
  assign word = idata;

  assign au_instr  = word.au;
  assign ls_instr  = word.ls;
  assign au_op_vld = dec_vld && !word.au.cls;
  assign ls_op_vld = dec_vld && word.ls.cls;

  // Branch offsets are signed and counted in instruction words
  assign br_field = {word.au.ra, word.au.is_imm, word.au.imm_b3, word.au.rb};
  assign br_off   = {{(`BARREL_IADDR_W - 8){br_field[7]}}, br_field};

  // Bz looks at the zero flag left by this slice's previous result
  always_comb begin
    taken = 1'b0;
    if (au_op_vld) begin
      case (word.au.op)
        OP_BRA:  taken = 1'b1;
        OP_BZ:   taken = au_flags[slice];
        default: taken = 1'b0;
      endcase
    end
  end

  assign next_slice = fetch_slice + 1'b1;

  // Fetch slice leads the decode slice by one cycle
  // The first cycle after reset has nothing on idata yet, so decode waits for dec_vld
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      fetch_slice <= '0;
      slice       <= '0;
      dec_vld     <= 1'b0;
      iaddr       <= '0;
    end else begin
      fetch_slice <= next_slice;
      slice       <= fetch_slice;
      dec_vld     <= 1'b1;
      iaddr       <= pc[next_slice];
    end
  end

  // A slice's counter moves only in its own decode cycle, which is well
  // before the counter is read again for that slice's next fetch
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int s = 0; s < `BARREL_SLICES; s++) begin
        pc[s] <= `BARREL_IADDR_W'(s * `BARREL_SLICE_BASE);
      end
    end else if (dec_vld) begin
      if (taken) begin
        pc[slice] <= pc[slice] + br_off;
      end else begin
        pc[slice] <= pc[slice] + 1'b1;
      end
    end
  end

endmodule

//--- hw/barrel_regfile.sv
// Register arrays of all slices with four read ports and two write ports
`timescale 1ns/10ps
`include "barrel_settings.svh"

module barrel_regfile (
  input  logic                        clk,
  input  logic                        arst_n,
  input  logic [`BARREL_SLICE_W-1:0]  slice,
  input  logic [`BARREL_REG_W-1:0]    au_ra_sel,
  input  logic [`BARREL_REG_W-1:0]    au_rb_sel,
  input  logic [`BARREL_REG_W-1:0]    ls_ptr_sel,
  input  logic [`BARREL_REG_W-1:0]    ls_store_sel,
  input  logic                        au_rc_vld,
  input  logic [`BARREL_SLICE_W-1:0]  au_rc_slice,
  input  logic [`BARREL_REG_W-1:0]    au_rc_sel,
  input  logic [`BARREL_DATA_W-1:0]   au_rc,
  input  logic                        ls_load_vld,
  input  logic [`BARREL_SLICE_W-1:0]  ls_load_slice,
  input  logic [`BARREL_REG_W-1:0]    ls_load_sel,
  input  logic [`BARREL_DATA_W-1:0]   ls_load,
  output logic [`BARREL_DATA_W-1:0]   au_ra,
  output logic [`BARREL_DATA_W-1:0]   au_rb,
  output logic [`BARREL_DATA_W-1:0]   ls_ptr,
  output logic [`BARREL_DATA_W-1:0]   ls_store
);

  logic [`BARREL_DATA_W-1:0] rf [`BARREL_SLICES][`BARREL_REGS];

  // All reads come from the slice currently in decode
  assign au_ra    = rf[slice][au_ra_sel];
  assign au_rb    = rf[slice][au_rb_sel];
  assign ls_ptr   = rf[slice][ls_ptr_sel];
  assign ls_store = rf[slice][ls_store_sel];

  // ALU results and load data always belong to different slices in a
  // given cycle, so the two write ports never collide
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int s = 0; s < `BARREL_SLICES; s++) begin
        for (int r = 0; r < `BARREL_REGS; r++) begin
          rf[s][r] <= '0;
        end
      end
    end else begin
      if (au_rc_vld) begin
        rf[au_rc_slice][au_rc_sel] <= au_rc;
      end
      if (ls_load_vld) begin
        rf[ls_load_slice][ls_load_sel] <= ls_load;
      end
    end
  end

endmodule

//--- hw/barrel_alu.sv
// Arithmetic unit with operand selection, registered result and per-slice zero flags
`timescale 1ns/10ps
`include "barrel_settings.svh"

module barrel_alu import barrel_pkg::*; (
  input  logic                        clk,
  input  logic                        arst_n,
  input  logic [`BARREL_SLICE_W-1:0]  slice,
  input  logic                        au_op_vld,
  input  au_instr_t                   au_instr,
  input  logic [`BARREL_DATA_W-1:0]   au_ra,
  input  logic [`BARREL_DATA_W-1:0]   au_rb,
  output logic [`BARREL_REG_W-1:0]    au_ra_sel,
  output logic [`BARREL_REG_W-1:0]    au_rb_sel,
  output logic                        au_rc_vld,
  output logic [`BARREL_SLICE_W-1:0]  au_rc_slice,
  output logic [`BARREL_REG_W-1:0]    au_rc_sel,
  output logic [`BARREL_DATA_W-1:0]   au_rc,
  output logic [`BARREL_SLICES-1:0]   au_flags
);

  logic [4:0]                imm5;
  logic [7:0]                imm8;
  logic [`BARREL_DATA_W-1:0] opnd_b;
  logic [4:0]                shamt;
  logic [`BARREL_DATA_W-1:0] result;
  logic                      writes;

  assign au_ra_sel = au_instr.ra;
  assign au_rb_sel = au_instr.rb;

  // Immediates are zero-extended
  assign imm5   = {au_instr.is_imm, au_instr.imm_b3, au_instr.rb};
  assign imm8   = {au_instr.ra, imm5};
  assign opnd_b = au_instr.is_imm ? `BARREL_DATA_W'(imm5) : au_rb;
  assign shamt  = opnd_b[4:0];

  always_comb begin
    result = '0;
    writes = 1'b1;
    case (au_instr.op)
      OP_ADD:  result = au_ra + opnd_b;
      OP_SUB:  result = au_ra - opnd_b;
      OP_AND:  result = au_ra & opnd_b;
      OP_OR:   result = au_ra | opnd_b;
      OP_XOR:  result = au_ra ^ opnd_b;
      OP_SHL:  result = au_ra << shamt;
      OP_SHR:  result = au_ra >> shamt;
      OP_MOVI: result = `BARREL_DATA_W'(imm8);
      // Branches are resolved in fetch and leave registers and flags alone
      default: writes = 1'b0;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      au_rc_vld <= 1'b0;
      au_flags  <= '0;
    end else begin
      au_rc_vld <= au_op_vld && writes;
      if (au_op_vld && writes) begin
        au_flags[slice] <= (result == '0);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (au_op_vld) begin
      au_rc_slice <= slice;
      au_rc_sel   <= au_instr.rd;
      au_rc       <= result;
    end
  end

endmodule

//--- hw/barrel_lsu.sv
// Load/store unit driving the registered data bus and aligning load data
`timescale 1ns/10ps
`include "barrel_settings.svh"

module barrel_lsu import barrel_pkg::*; (
  input  logic                        clk,
  input  logic                        arst_n,
  input  logic [`BARREL_SLICE_W-1:0]  slice,
  input  logic                        ls_op_vld,
  input  ls_instr_t                   ls_instr,
  input  logic [`BARREL_DATA_W-1:0]   ls_ptr,
  input  logic [`BARREL_DATA_W-1:0]   ls_store,
  input  logic [`BARREL_DATA_W-1:0]   din,
  output logic [`BARREL_REG_W-1:0]    ls_ptr_sel,
  output logic [`BARREL_REG_W-1:0]    ls_store_sel,
  output logic [`BARREL_DATA_W-1:0]   daddr,
  output logic                        dcs,
  output logic                        dwr,
  output logic [`BARREL_LANES-1:0]    dmask,
  output logic [`BARREL_DATA_W-1:0]   dout,
  output logic                        ls_load_vld,
  output logic [`BARREL_SLICE_W-1:0]  ls_load_slice,
  output logic [`BARREL_REG_W-1:0]    ls_load_sel,
  output logic [`BARREL_DATA_W-1:0]   ls_load
);

  localparam int LANE_W = $clog2(`BARREL_LANES);

  logic [`BARREL_DATA_W-1:0]  addr;
  logic [`BARREL_LANES-1:0]   lane_mask;
  logic [`BARREL_SLICE_W-1:0] req_slice;
  logic [`BARREL_REG_W-1:0]   req_sel;
  logic                       req_byte;
  logic                       ld_byte;
  logic [LANE_W-1:0]          ld_lane;

  assign ls_ptr_sel   = ls_instr.ptr;
  assign ls_store_sel = ls_instr.rd;

  // The offset counts words, so it is scaled to bytes before the add
  assign addr      = ls_ptr + (`BARREL_DATA_W'(ls_instr.offset) << 2);
  assign lane_mask = `BARREL_LANES'(1) << addr[LANE_W-1:0];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      dcs         <= 1'b0;
      dwr         <= 1'b0;
      ls_load_vld <= 1'b0;
    end else begin
      dcs         <= ls_op_vld;
      dwr         <= ls_op_vld && !ls_instr.load;
      // Read data comes back one cycle after the request is on the bus
      ls_load_vld <= dcs && !dwr;
    end
  end

  always_ff @(posedge clk) begin
    if (ls_op_vld) begin
      daddr     <= addr;
      dmask     <= ls_instr.byte_op ? lane_mask : '1;
      // Byte stores put the same byte on every lane and let the mask pick one
      dout      <= ls_instr.byte_op ? {`BARREL_LANES{ls_store[7:0]}} : ls_store;
      req_slice <= slice;
      req_sel   <= ls_instr.rd;
      req_byte  <= ls_instr.byte_op;
    end
    ls_load_slice <= req_slice;
    ls_load_sel   <= req_sel;
    ld_byte       <= req_byte;
    ld_lane       <= daddr[LANE_W-1:0];
  end

  assign ls_load = ld_byte ? `BARREL_DATA_W'(din[ld_lane*8 +: 8]) : din;

endmodule

//--- hw/barrel_core.sv
// Barrel-threaded core top level joining fetch, register file, ALU and load/store unit
`timescale 1ns/10ps
`include "barrel_settings.svh"

module barrel_core import barrel_pkg::*; (
  input  logic                        clk,
  input  logic                        arst_n,
  output logic [`BARREL_IADDR_W-1:0]  iaddr,
  input  logic [`BARREL_INSTR_W-1:0]  idata,
  output logic [`BARREL_DATA_W-1:0]   daddr,
  output logic                        dcs,
  output logic                        dwr,
  output logic [`BARREL_LANES-1:0]    dmask,
  output logic [`BARREL_DATA_W-1:0]   dout,
  input  logic [`BARREL_DATA_W-1:0]   din
);

  logic [`BARREL_SLICE_W-1:0] slice;
  logic [`BARREL_SLICES-1:0]  au_flags;
  logic                       au_op_vld;
  au_instr_t                  au_instr;
  logic                       ls_op_vld;
  ls_instr_t                  ls_instr;

  logic [`BARREL_REG_W-1:0]   au_ra_sel;
  logic [`BARREL_REG_W-1:0]   au_rb_sel;
  logic [`BARREL_DATA_W-1:0]  au_ra;
  logic [`BARREL_DATA_W-1:0]  au_rb;
  logic                       au_rc_vld;
  logic [`BARREL_SLICE_W-1:0] au_rc_slice;
  logic [`BARREL_REG_W-1:0]   au_rc_sel;
  logic [`BARREL_DATA_W-1:0]  au_rc;

  logic [`BARREL_REG_W-1:0]   ls_ptr_sel;
  logic [`BARREL_REG_W-1:0]   ls_store_sel;
  logic [`BARREL_DATA_W-1:0]  ls_ptr;
  logic [`BARREL_DATA_W-1:0]  ls_store;
  logic                       ls_load_vld;
  logic [`BARREL_SLICE_W-1:0] ls_load_slice;
  logic [`BARREL_REG_W-1:0]   ls_load_sel;
  logic [`BARREL_DATA_W-1:0]  ls_load;

  barrel_fetch barrel_fetch_inst (
    .clk       (clk),
    .arst_n    (arst_n),
    .idata     (idata),
    .au_flags  (au_flags),
    .iaddr     (iaddr),
    .slice     (slice),
    .au_op_vld (au_op_vld),
    .au_instr  (au_instr),
    .ls_op_vld (ls_op_vld),
    .ls_instr  (ls_instr)
  );

  barrel_regfile barrel_regfile_inst (
    .clk           (clk),
    .arst_n        (arst_n),
    .slice         (slice),
    .au_ra_sel     (au_ra_sel),
    .au_rb_sel     (au_rb_sel),
    .ls_ptr_sel    (ls_ptr_sel),
    .ls_store_sel  (ls_store_sel),
    .au_rc_vld     (au_rc_vld),
    .au_rc_slice   (au_rc_slice),
    .au_rc_sel     (au_rc_sel),
    .au_rc         (au_rc),
    .ls_load_vld   (ls_load_vld),
    .ls_load_slice (ls_load_slice),
    .ls_load_sel   (ls_load_sel),
    .ls_load       (ls_load),
    .au_ra         (au_ra),
    .au_rb         (au_rb),
    .ls_ptr        (ls_ptr),
    .ls_store      (ls_store)
  );

  barrel_alu barrel_alu_inst (
    .clk         (clk),
    .arst_n      (arst_n),
    .slice       (slice),
    .au_op_vld   (au_op_vld),
    .au_instr    (au_instr),
    .au_ra       (au_ra),
    .au_rb       (au_rb),
    .au_ra_sel   (au_ra_sel),
    .au_rb_sel   (au_rb_sel),
    .au_rc_vld   (au_rc_vld),
    .au_rc_slice (au_rc_slice),
    .au_rc_sel   (au_rc_sel),
    .au_rc       (au_rc),
    .au_flags    (au_flags)
  );

  barrel_lsu barrel_lsu_inst (
    .clk           (clk),
    .arst_n        (arst_n),
    .slice         (slice),
    .ls_op_vld     (ls_op_vld),
    .ls_instr      (ls_instr),
    .ls_ptr        (ls_ptr),
    .ls_store      (ls_store),
    .din           (din),
    .ls_ptr_sel    (ls_ptr_sel),
    .ls_store_sel  (ls_store_sel),
    .daddr         (daddr),
    .dcs           (dcs),
    .dwr           (dwr),
    .dmask         (dmask),
    .dout          (dout),
    .ls_load_vld   (ls_load_vld),
    .ls_load_slice (ls_load_slice),
    .ls_load_sel   (ls_load_sel),
    .ls_load       (ls_load)
  );

endmodule

//--- bench/barrel_core_props.sv
// Bus protocol assertions for the data and instruction ports of the core
`timescale 1ns/10ps
`include "barrel_settings.svh"

module barrel_core_props (
  input logic                        clk,
  input logic                        arst_n,
  input logic [`BARREL_IADDR_W-1:0]  iaddr,
  input logic [`BARREL_DATA_W-1:0]   daddr,
  input logic                        dcs,
  input logic                        dwr,
  input logic [`BARREL_LANES-1:0]    dmask
);

  // A write strobe without a chip select is never valid
  assert property (@(posedge clk) disable iff (!arst_n) dwr |-> dcs)
    else $error("dwr raised while dcs is low");

  // Writes enable either the whole word or exactly one lane
  assert property (@(posedge clk) disable iff (!arst_n)
    (dcs && dwr) |-> (dmask == '1 || $onehot(dmask)))
    else $error("write mask is neither a full word nor a single lane");

  // A single-lane write uses the lane named by the low address bits
  assert property (@(posedge clk) disable iff (!arst_n)
    (dcs && dwr && $onehot(dmask)) |-> (dmask == (`BARREL_LANES'(1) << daddr[1:0])))
    else $error("byte write mask does not match the address lane");

  // Word requests are aligned
  assert property (@(posedge clk) disable iff (!arst_n)
    (dcs && dmask == '1) |-> (daddr[1:0] == 2'b00))
    else $error("word access on an unaligned address");

  assert property (@(posedge clk) disable iff (!arst_n) !$isunknown(iaddr))
    else $error("instruction address is unknown");

  assert property (@(posedge clk) disable iff (!arst_n) !$isunknown(dcs))
    else $error("data chip select is unknown");

endmodule

//--- bench/barrel_core_tb.sv
// Testbench for the barrel core with memory models, case table, program builder and checks
`timescale 1ns/10ps
`include "barrel_settings.svh"

module barrel_core_tb import barrel_pkg::*; ();

  localparam int NUM_ROWS    = 12;
  localparam int NUM_BATCHES = NUM_ROWS / `BARREL_SLICES;
  localparam int PROG_LEN    = 12;
  localparam int CYCLE_LIMIT = NUM_BATCHES * (PROG_LEN * 4 + 20);

  typedef struct {
    opcode_e    op;
    bit         use_imm;
    logic [7:0] a;
    logic [7:0] b;
    bit         byte_st;
    bit         taken;
  } case_t;

  logic                        clk;
  logic                        arst_n;
  logic [`BARREL_IADDR_W-1:0]  iaddr;
  logic [`BARREL_INSTR_W-1:0]  idata;
  logic [`BARREL_DATA_W-1:0]   daddr;
  logic                        dcs;
  logic                        dwr;
  logic [`BARREL_LANES-1:0]    dmask;
  logic [`BARREL_DATA_W-1:0]   dout;
  logic [`BARREL_DATA_W-1:0]   din;

  logic [`BARREL_INSTR_W-1:0]  rom [1 << `BARREL_IADDR_W];
  logic [`BARREL_DATA_W-1:0]   ram [64];
  case_t                       cases [NUM_ROWS];
  logic [`BARREL_DATA_W-1:0]   exp_res [`BARREL_SLICES];
  logic [1:0]                  exp_lane [`BARREL_SLICES];
  bit                          exp_byte [`BARREL_SLICES];
  bit                          exp_taken [`BARREL_SLICES];
  int                          seen [`BARREL_SLICES][8];
  bit [`BARREL_SLICES-1:0]     reached;
  int                          cycles;

  barrel_core barrel_core_inst (
    .clk    (clk),
    .arst_n (arst_n),
    .iaddr  (iaddr),
    .idata  (idata),
    .daddr  (daddr),
    .dcs    (dcs),
    .dwr    (dwr),
    .dmask  (dmask),
    .dout   (dout),
    .din    (din)
  );

  bind barrel_core barrel_core_props barrel_core_props_inst (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Instruction ROM and byte-masked data RAM answer one cycle after the request
  always @(posedge clk) begin
    idata <= #1 rom[iaddr];
    if (dcs && dwr) begin
      for (int l = 0; l < `BARREL_LANES; l++) begin
        if (dmask[l]) ram[daddr[7:2]][l*8 +: 8] <= dout[l*8 +: 8];
      end
    end else if (dcs) begin
      din <= #1 ram[daddr[7:2]];
    end
  end

  always @(posedge clk) begin
    if (arst_n) begin
      cycles <= cycles + 1;
      if (cycles >= CYCLE_LIMIT) begin
        $display("Timeout: the programs did not finish within %0d cycles", CYCLE_LIMIT);
        report_failure();
      end
    end
  end

  task automatic report_failure();
    $display("Some tests failed");
    $fatal(1, "simulation stopped after a failure");
  endtask

  task automatic flag_error(string msg);
    $display("CHECK FAILED at %0t ns: %s", $time, msg);
    report_failure();
  endtask

  task automatic check_store(string what, logic [`BARREL_DATA_W-1:0] addr_got,
      logic [`BARREL_DATA_W-1:0] addr_exp, logic [`BARREL_DATA_W-1:0] data_got,
      logic [`BARREL_DATA_W-1:0] data_exp, logic [`BARREL_LANES-1:0] mask_got,
      logic [`BARREL_LANES-1:0] mask_exp);
    if (addr_got !== addr_exp || data_got !== data_exp || mask_got !== mask_exp) begin
      flag_error($sformatf("%s: got addr %h data %h mask %b, expected %h %h %b", what,
        addr_got, data_got, mask_got, addr_exp, data_exp, mask_exp));
    end
  endtask

  task automatic check_branch(int s, logic taken_got, logic taken_exp);
    if (taken_got !== taken_exp) begin
      flag_error($sformatf("slice %0d branch taken %b, expected %b", s, taken_got, taken_exp));
    end
  endtask

  task automatic check_ram(int idx, logic [`BARREL_DATA_W-1:0] got,
      logic [`BARREL_DATA_W-1:0] exp);
    if (got !== exp) begin
      flag_error($sformatf("RAM word %0d holds %h, expected %h", idx, got, exp));
    end
  endtask

  task automatic check_iaddr(logic [`BARREL_IADDR_W-1:0] got, logic [`BARREL_IADDR_W-1:0] exp);
    if (got !== exp) begin
      flag_error($sformatf("iaddr %0d after reset, expected %0d", got, exp));
    end
  endtask

  // Background fill that depends on the whole word index
  function automatic logic [`BARREL_DATA_W-1:0] fill_word(int idx);
    return (idx * 32'h9e37_79b9) ^ 32'h5a5a_0f0f;
  endfunction

  function automatic logic [`BARREL_DATA_W-1:0] model_op(opcode_e op,
      logic [`BARREL_DATA_W-1:0] a, logic [`BARREL_DATA_W-1:0] b);
    case (op)
      OP_ADD:  return a + b;
      OP_AND:  return a & b;
      OP_OR:   return a | b;
      OP_XOR:  return a ^ b;
      OP_SHL:  return a << b[4:0];
      OP_SHR:  return a >> b[4:0];
      OP_MOVI: return a;
      default: return a - b;
    endcase
  endfunction

  function automatic logic [15:0] enc_reg(opcode_e op, logic [2:0] rd, logic [2:0] ra,
      logic [2:0] rb);
    instr_u u;
    u = '0;
    u.au.op = op;
    u.au.rd = rd;
    u.au.ra = ra;
    u.au.rb = rb;
    return u;
  endfunction

  // The immediate flag is bit 4 of the 5-bit immediate, so imm5 is 16 plus imm4
  function automatic logic [15:0] enc_imm(opcode_e op, logic [2:0] rd, logic [2:0] ra,
      logic [3:0] imm4);
    instr_u u;
    u = '0;
    u.au.op     = op;
    u.au.rd     = rd;
    u.au.ra     = ra;
    u.au.is_imm = 1'b1;
    u.au.imm_b3 = imm4[3];
    u.au.rb     = imm4[2:0];
    return u;
  endfunction

  function automatic logic [15:0] enc_i8(opcode_e op, logic [2:0] rd, logic [7:0] v);
    instr_u u;
    u = '0;
    u.au.op     = op;
    u.au.rd     = rd;
    u.au.ra     = v[7:5];
    u.au.is_imm = v[4];
    u.au.imm_b3 = v[3];
    u.au.rb     = v[2:0];
    return u;
  endfunction

  function automatic logic [15:0] enc_mem(bit load, bit byte_op, logic [2:0] rd,
      logic [2:0] ptr, logic [4:0] off);
    instr_u u;
    u = '0;
    u.ls.cls     = 1'b1;
    u.ls.load    = load;
    u.ls.byte_op = byte_op;
    u.ls.rd      = rd;
    u.ls.ptr     = ptr;
    u.ls.offset  = off;
    return u;
  endfunction

  task automatic fill_table();
    cases[0]  = '{OP_ADD,  0, 8'd0,   8'd0,  0, 0};
    cases[1]  = '{OP_SUB,  0, 8'h40,  8'h40, 0, 0};
    cases[2]  = '{OP_AND,  1, 8'd0,   8'h0b, 0, 0};
    cases[3]  = '{OP_OR,   0, 8'd0,   8'd0,  0, 0};
    cases[4]  = '{OP_XOR,  0, 8'd0,   8'd0,  1, 0};
    cases[5]  = '{OP_SHL,  1, 8'h9d,  8'h03, 0, 0};
    cases[6]  = '{OP_SHR,  0, 8'hff,  8'h03, 0, 0};
    cases[7]  = '{OP_MOVI, 0, 8'h9c,  8'h00, 1, 0};
    cases[8]  = '{OP_BZ,   0, 8'h07,  8'h07, 0, 1};
    cases[9]  = '{OP_BZ,   0, 8'h07,  8'h03, 0, 0};
    cases[10] = '{OP_BRA,  0, 8'h01,  8'h02, 0, 1};
    cases[11] = '{OP_ADD,  1, 8'd0,   8'h05, 1, 0};
  endtask

  // Slice s uses RAM words 8s..8s+4 and its program area at s * BARREL_SLICE_BASE
  task automatic load_batch(int batch);
    case_t                     row;
    logic [7:0]                a;
    logic [7:0]                b;
    logic [`BARREL_DATA_W-1:0] b_eff;
    opcode_e                   opc;
    int                        base;
    logic [4:0]                w;
    for (int i = 0; i < (1 << `BARREL_IADDR_W); i++) rom[i] = '0;
    for (int i = 0; i < 64; i++) ram[i] = fill_word(i);
    reached = '0;
    for (int s = 0; s < `BARREL_SLICES; s++) begin
      row = cases[batch * `BARREL_SLICES + s];
      a = (row.a == 0) ? 8'($urandom) : row.a;
      b = (row.b == 0) ? 8'($urandom) : row.b;
      opc = (row.op == OP_BZ || row.op == OP_BRA) ? OP_SUB : row.op;
      base = s * `BARREL_SLICE_BASE;
      w = 5'(s * 8);
      exp_byte[s] = row.byte_st;
      exp_lane[s] = row.byte_st ? 2'((batch + s) % 3 + 1) : 2'd0;
      b_eff = row.use_imm ? (32'h10 | b[3:0]) : 32'(b);
      exp_res[s] = model_op(opc, 32'(a), b_eff);
      if (row.op == OP_BRA) exp_taken[s] = 1'b1;
      else if (row.op == OP_BZ) exp_taken[s] = row.taken;
      else exp_taken[s] = (exp_res[s] == 0);
      for (int k = 0; k < 8; k++) seen[s][k] = 0;
      rom[base + 0] = enc_i8(OP_MOVI, 3'd1, a);
      rom[base + 1] = enc_i8(OP_MOVI, 3'd2, b);
      rom[base + 2] = enc_i8(OP_MOVI, 3'd5, 8'(exp_lane[s]));
      if (opc == OP_MOVI) rom[base + 3] = enc_i8(OP_MOVI, 3'd3, a);
      else if (row.use_imm) rom[base + 3] = enc_imm(opc, 3'd3, 3'd1, b[3:0]);
      else rom[base + 3] = enc_reg(opc, 3'd3, 3'd1, 3'd2);
      rom[base + 4]  = enc_mem(0, row.byte_st, 3'd3, 3'd5, w);
      rom[base + 5]  = enc_mem(1, 0, 3'd4, 3'd0, w + 5'd1);
      rom[base + 6]  = enc_mem(0, 0, 3'd4, 3'd0, w + 5'd2);
      rom[base + 7]  = enc_mem(1, 1, 3'd6, 3'd5, w + 5'd1);
      rom[base + 8]  = enc_mem(0, 0, 3'd6, 3'd0, w + 5'd3);
      rom[base + 9]  = enc_i8(row.op == OP_BRA ? OP_BRA : OP_BZ, 3'd0, 8'd2);
      rom[base + 10] = enc_mem(0, 0, 3'd3, 3'd0, w + 5'd4);
      rom[base + 11] = enc_i8(OP_BRA, 3'd0, 8'd0);
    end
  endtask

  task automatic handle_store(logic [`BARREL_DATA_W-1:0] addr,
      logic [`BARREL_DATA_W-1:0] data, logic [`BARREL_LANES-1:0] mask);
    int                        s;
    int                        k;
    logic [`BARREL_DATA_W-1:0] w1;
    s = addr[7:2] / 8;
    k = addr[7:2] % 8;
    w1 = fill_word(s * 8 + 1);
    if (s >= `BARREL_SLICES) begin
      flag_error($sformatf("store to address %h outside every slice's area", addr));
    end
    seen[s][k]++;
    case (k)
      0: begin
        if (exp_byte[s]) begin
          check_store("byte result", addr, 32'(s * 32 + exp_lane[s]), data,
            {4{exp_res[s][7:0]}}, mask, `BARREL_LANES'(1) << exp_lane[s]);
        end else begin
          check_store("word result", addr, 32'(s * 32), data, exp_res[s], mask, '1);
        end
      end
      2: check_store("word copy", addr, 32'(s * 32 + 8), data, w1, mask, '1);
      3: check_store("byte load", addr, 32'(s * 32 + 12), data,
           32'(w1[exp_lane[s]*8 +: 8]), mask, '1);
      4: begin
        check_branch(s, 1'b0, exp_taken[s]);
        check_store("marker", addr, 32'(s * 32 + 16), data, exp_res[s], mask, '1);
      end
      default: flag_error($sformatf("slice %0d stored to unexpected address %h", s, addr));
    endcase
  endtask

  always @(negedge clk) begin
    if (arst_n) begin
      for (int s = 0; s < `BARREL_SLICES; s++) begin
        if (iaddr == s * `BARREL_SLICE_BASE + PROG_LEN - 1) reached[s] = 1'b1;
      end
      if (dcs && dwr) handle_store(daddr, dout, dmask);
    end
  end

  task automatic check_results();
    logic [`BARREL_DATA_W-1:0] w0;
    for (int s = 0; s < `BARREL_SLICES; s++) begin
      if (seen[s][0] != 1 || seen[s][2] != 1 || seen[s][3] != 1) begin
        $display("Slice %0d did not issue each of its data stores exactly once", s);
        report_failure();
      end
      if (!exp_taken[s] && seen[s][4] != 1) begin
        $display("Slice %0d skipped its marker store although bz should fall through", s);
        report_failure();
      end
      w0 = fill_word(s * 8);
      if (exp_byte[s]) w0[exp_lane[s]*8 +: 8] = exp_res[s][7:0];
      else w0 = exp_res[s];
      check_ram(s * 8, ram[s * 8], w0);
    end
  endtask

  initial begin
    arst_n = 1'b0;
    idata = '0;
    din = '0;
    cycles = 0;
    void'($urandom(32'hbe12_9676));
    fill_table();
    for (int batch = 0; batch < NUM_BATCHES; batch++) begin
      @(posedge clk);
      #1 arst_n = 1'b0;
      load_batch(batch);
      repeat (10) @(posedge clk);
      #1 arst_n = 1'b1;
      // Fetch starts at slice 0 and walks the slice start addresses in order
      for (int k = 0; k < `BARREL_SLICES; k++) begin
        @(negedge clk);
        check_iaddr(iaddr, `BARREL_IADDR_W'(k * `BARREL_SLICE_BASE));
        if (dcs !== 1'b0) flag_error("dcs not low before any instruction completed");
      end
      while (!(&reached)) @(negedge clk);
      // Let the stores still in flight reach the bus
      repeat (8) @(negedge clk);
      check_results();
    end
    $display("All tests passed");
    $finish;
  end

endmodule

//--- barrel_core.f
+incdir+hw
hw/barrel_pkg.sv
hw/barrel_fetch.sv
hw/barrel_regfile.sv
hw/barrel_alu.sv
hw/barrel_lsu.sv
hw/barrel_core.sv
bench/barrel_core_props.sv
bench/barrel_core_tb.sv

//--- Bender.yml
package:
  name: barrel_core

sources:
  - include_dirs:
      - hw
    files:
      - hw/barrel_pkg.sv
      - hw/barrel_fetch.sv
      - hw/barrel_regfile.sv
      - hw/barrel_alu.sv
      - hw/barrel_lsu.sv
      - hw/barrel_core.sv
  - target: test
    include_dirs:
      - hw
    files:
      - bench/barrel_core_props.sv
      - bench/barrel_core_tb.sv
